//--- cluster_periph_pkg.sv
// fixed for 8 cores and a 12-bit word address; the top nibble picks the unit, low byte the register
`default_nettype none

package cluster_periph_pkg;

  localparam int unsigned NB_CORES = 8;
  localparam int unsigned ADDR_W   = 12;
  localparam int unsigned DATA_W   = 32;

  // address split into unit select and register offset
  localparam int unsigned SEL_W  = 4;
  localparam int unsigned OFFS_W = 8;

  localparam logic [SEL_W-1:0] CTRL_BASE  = 4'h0;
  localparam logic [SEL_W-1:0] TIMER_BASE = 4'h1;

  localparam logic [DATA_W-1:0] BOOT_ADDR_RESET = 32'h1C00_0000;

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } periph_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } periph_rsp_t;

  typedef enum logic [1:0] {
    TGT_CTRL,
    TGT_TIMER,
    TGT_NONE
  } periph_target_e;

  typedef enum logic [OFFS_W-1:0] {
    CTRL_EOC       = 8'h00,
    CTRL_FETCH_EN  = 8'h04,
    CTRL_BOOT_ADDR = 8'h08
  } ctrl_reg_e;

  // status bit 0 is write-one-to-clear
  typedef enum logic [OFFS_W-1:0] {
    TMR_CFG    = 8'h00,
    TMR_COUNT  = 8'h04,
    TMR_CMP    = 8'h08,
    TMR_STATUS = 8'h0C
  } timer_reg_e;

endpackage

`default_nettype wire

//--- cluster_ctrl_unit.sv
// one boot address shared by all cores; unknown offsets answer with the error bit set
`timescale 1ns/100ps
`default_nettype none

module cluster_ctrl_unit (
  input  wire logic                                     clk_i,
  input  wire logic                                     rst_n_i,
  input  wire logic                                     sel_i,
  input  wire cluster_periph_pkg::periph_req_t          req_i,
  output cluster_periph_pkg::periph_rsp_t               rsp_o,
  output logic                                          eoc_o,
  output logic [cluster_periph_pkg::NB_CORES-1:0]       fetch_enable_o,
  output logic [cluster_periph_pkg::DATA_W-1:0]         boot_addr_o
);

  logic [cluster_periph_pkg::OFFS_W-1:0]   offs;
  logic                                    hit;
  logic [cluster_periph_pkg::DATA_W-1:0]   rd_data;

  logic                                    eoc_q;
  logic [cluster_periph_pkg::NB_CORES-1:0] fetch_en_q;
  logic [cluster_periph_pkg::DATA_W-1:0]   boot_addr_q;
  cluster_periph_pkg::periph_rsp_t         rsp_q;

  assign offs = req_i.addr[cluster_periph_pkg::OFFS_W-1:0];

  // ************************************************************************
  // register decode
  // ************************************************************************

  always_comb begin
    hit     = 1'b1;
    rd_data = '0;
    case (offs)
      cluster_periph_pkg::CTRL_EOC: begin
        rd_data[0] = eoc_q;
      end
      cluster_periph_pkg::CTRL_FETCH_EN: begin
        rd_data[cluster_periph_pkg::NB_CORES-1:0] = fetch_en_q;
      end
      cluster_periph_pkg::CTRL_BOOT_ADDR: begin
        rd_data = boot_addr_q;
      end
      default: begin
        hit = 1'b0;
      end
    endcase
  end

  // writes land on the strobe edge, so outputs move with the accepted request
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      eoc_q       <= 1'b0;
      fetch_en_q  <= '0;
      boot_addr_q <= cluster_periph_pkg::BOOT_ADDR_RESET;
    end else if (sel_i && req_i.we) begin
      case (offs)
        cluster_periph_pkg::CTRL_EOC:       eoc_q       <= req_i.wdata[0];
        cluster_periph_pkg::CTRL_FETCH_EN: begin
          fetch_en_q <= req_i.wdata[cluster_periph_pkg::NB_CORES-1:0];
        end
        cluster_periph_pkg::CTRL_BOOT_ADDR: boot_addr_q <= req_i.wdata;
        default: ;
      endcase
    end
  end

  // ************************************************************************
  // response one cycle after the strobe
  // ************************************************************************

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rsp_q.rdata <= req_i.we ? '0 : rd_data;
      rsp_q.err   <= !hit;
    end
  end

  assign rsp_o          = rsp_q;
  assign eoc_o          = eoc_q;
  assign fetch_enable_o = fetch_en_q;
  assign boot_addr_o    = boot_addr_q;

endmodule

`default_nettype wire

//--- cluster_timer.sv
// counts on clk_i with a 32-bit count that wraps silently; match status is sticky until cleared
`timescale 1ns/100ps
`default_nettype none

module cluster_timer (
  input  wire logic                            clk_i,
  input  wire logic                            rst_n_i,
  input  wire logic                            sel_i,
  input  wire cluster_periph_pkg::periph_req_t req_i,
  output cluster_periph_pkg::periph_rsp_t      rsp_o,
  output logic                                 evt_o
);

  logic [cluster_periph_pkg::OFFS_W-1:0] offs;
  logic                                  hit;
  logic                                  wr;
  logic [cluster_periph_pkg::DATA_W-1:0] rd_data;

  logic                                  enable_q;
  logic [cluster_periph_pkg::DATA_W-1:0] count_q;
  logic [cluster_periph_pkg::DATA_W-1:0] cmp_q;
  logic                                  match_q;
  cluster_periph_pkg::periph_rsp_t       rsp_q;

  assign offs = req_i.addr[cluster_periph_pkg::OFFS_W-1:0];
  assign wr   = sel_i && req_i.we;

  always_comb begin
    hit     = 1'b1;
    rd_data = '0;
    case (offs)
      cluster_periph_pkg::TMR_CFG:    rd_data[0] = enable_q;
      cluster_periph_pkg::TMR_COUNT:  rd_data    = count_q;
      cluster_periph_pkg::TMR_CMP:    rd_data    = cmp_q;
      cluster_periph_pkg::TMR_STATUS: rd_data[0] = match_q;
      default:                        hit        = 1'b0;
    endcase
  end

  // ************************************************************************
  // configuration registers
  // ************************************************************************

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      enable_q <= 1'b0;
      cmp_q    <= '0;
    end else if (wr) begin
      if (offs == cluster_periph_pkg::TMR_CFG) begin
        enable_q <= req_i.wdata[0];
      end
      if (offs == cluster_periph_pkg::TMR_CMP) begin
        cmp_q <= req_i.wdata;
      end
    end
  end

  // ************************************************************************
  // counter and sticky match
  // ************************************************************************

  // a count load wins over the increment
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (wr && offs == cluster_periph_pkg::TMR_COUNT) begin
      count_q <= req_i.wdata;
    end else if (enable_q) begin
      count_q <= count_q + 1'b1;
    end
  end

  // a new match in the same cycle as a clear keeps the flag set
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      match_q <= 1'b0;
    end else begin
      if (wr && offs == cluster_periph_pkg::TMR_STATUS && req_i.wdata[0]) begin
        match_q <= 1'b0;
      end
      if (enable_q && count_q == cmp_q) begin
        match_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rsp_q.rdata <= req_i.we ? '0 : rd_data;
      rsp_q.err   <= !hit;
    end
  end

  assign rsp_o = rsp_q;
  assign evt_o = match_q;

endmodule

`default_nettype wire

//--- periph_bus_mux.sv
// one request outstanding at a time, fixed one-cycle latency; the response waits for rsp_ready_i
`timescale 1ns/100ps
`default_nettype none

module periph_bus_mux (
  input  wire logic                            clk_i,
  input  wire logic                            rst_n_i,

  input  wire logic                            req_valid_i,
  input  wire cluster_periph_pkg::periph_req_t req_i,
  output logic                                 req_ready_o,

  output logic                                 rsp_valid_o,
  output cluster_periph_pkg::periph_rsp_t      rsp_o,
  input  wire logic                            rsp_ready_i,

  output logic                                 ctrl_sel_o,
  output logic                                 timer_sel_o,
  input  wire cluster_periph_pkg::periph_rsp_t ctrl_rsp_i,
  input  wire cluster_periph_pkg::periph_rsp_t timer_rsp_i
);

  logic [cluster_periph_pkg::SEL_W-1:0] unit_sel;
  logic                                 accept;

  cluster_periph_pkg::periph_target_e   tgt_d;
  cluster_periph_pkg::periph_target_e   tgt_q;
  logic                                 pend_q;
  logic                                 rsp_valid_q;
  cluster_periph_pkg::periph_rsp_t      rsp_d;
  cluster_periph_pkg::periph_rsp_t      rsp_q;

  // ************************************************************************
  // request decode
  // ************************************************************************

  assign unit_sel = req_i.addr[cluster_periph_pkg::ADDR_W-1 -: cluster_periph_pkg::SEL_W];

  always_comb begin
    case (unit_sel)
      cluster_periph_pkg::CTRL_BASE:  tgt_d = cluster_periph_pkg::TGT_CTRL;
      cluster_periph_pkg::TIMER_BASE: tgt_d = cluster_periph_pkg::TGT_TIMER;
      default:                        tgt_d = cluster_periph_pkg::TGT_NONE;
    endcase
  end

  // no new request while one is in flight or a response is stuck
  assign req_ready_o = !pend_q && (!rsp_valid_q || rsp_ready_i);
  assign accept      = req_valid_i && req_ready_o;

  assign ctrl_sel_o  = accept && (tgt_d == cluster_periph_pkg::TGT_CTRL);
  assign timer_sel_o = accept && (tgt_d == cluster_periph_pkg::TGT_TIMER);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_q <= 1'b0;
      tgt_q  <= cluster_periph_pkg::TGT_NONE;
    end else begin
      pend_q <= accept;
      if (accept) begin
        tgt_q <= tgt_d;
      end
    end
  end

  // ************************************************************************
  // response select and hold
  // ************************************************************************

  always_comb begin
    case (tgt_q)
      cluster_periph_pkg::TGT_CTRL:  rsp_d = ctrl_rsp_i;
      cluster_periph_pkg::TGT_TIMER: rsp_d = timer_rsp_i;
      default:                       rsp_d = '{rdata: '0, err: 1'b1};
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (pend_q) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // pend_q implies the slot is free, so nothing held gets overwritten
  always_ff @(posedge clk_i) begin
    if (pend_q) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

//--- cluster_periph_top.sv
// register bus with one-cycle response latency; top address nibble 0 is control, 1 is timer
`timescale 1ns/100ps
`default_nettype none

module cluster_periph_top (
  input  wire logic                                clk_i,
  input  wire logic                                rst_n_i,

  // request and response streams
  input  wire logic                                req_valid_i,
  input  wire cluster_periph_pkg::periph_req_t     req_i,
  output logic                                     req_ready_o,
  output logic                                     rsp_valid_o,
  output cluster_periph_pkg::periph_rsp_t          rsp_o,
  input  wire logic                                rsp_ready_i,

  // cluster control outputs
  output logic                                     eoc_o,
  output logic [cluster_periph_pkg::NB_CORES-1:0]  fetch_enable_o,
  output logic [cluster_periph_pkg::DATA_W-1:0]    boot_addr_o,
  output logic                                     timer_evt_o
);

  logic                            ctrl_sel;
  logic                            timer_sel;
  cluster_periph_pkg::periph_rsp_t ctrl_rsp;
  cluster_periph_pkg::periph_rsp_t timer_rsp;

  // ************************************************************************
  // bus decode and response merge
  // ************************************************************************

  periph_bus_mux u_bus_mux (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .req_ready_o ( req_ready_o ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_o       ( rsp_o       ),
    .rsp_ready_i ( rsp_ready_i ),
    .ctrl_sel_o  ( ctrl_sel    ),
    .timer_sel_o ( timer_sel   ),
    .ctrl_rsp_i  ( ctrl_rsp    ),
    .timer_rsp_i ( timer_rsp   )
  );

  // ************************************************************************
  // units
  // ************************************************************************

  cluster_ctrl_unit u_ctrl (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .sel_i          ( ctrl_sel       ),
    .req_i          ( req_i          ),
    .rsp_o          ( ctrl_rsp       ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  cluster_timer u_timer (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .sel_i   ( timer_sel   ),
    .req_i   ( req_i       ),
    .rsp_o   ( timer_rsp   ),
    .evt_o   ( timer_evt_o )
  );

endmodule

`default_nettype wire

//--- tb_cluster_periph.sv
// run from the project root so cluster_periph_patterns.txt is found; one request in flight at a time
`timescale 1ns/100ps
`default_nettype none

module tb_cluster_periph;

  localparam logic [31:0] BOOT_RESET  = 32'h1C00_0000;
  localparam int          WDOG_CYCLES = 200;
  localparam int          EVT_WAIT    = 100;

  typedef struct packed {
    logic [7:0]  op;
    logic [11:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        err;
    logic [31:0] test;
  } pattern_t;

  logic                                          clk_i;
  logic                                          rst_n_i;
  logic                                          req_valid_i;
  cluster_periph_pkg::periph_req_t               req_i;
  logic                                          req_ready_o;
  logic                                          rsp_valid_o;
  cluster_periph_pkg::periph_rsp_t               rsp_o;
  logic                                          rsp_ready_i;
  logic                                          eoc_o;
  logic [cluster_periph_pkg::NB_CORES-1:0]       fetch_enable_o;
  logic [31:0]                                   boot_addr_o;
  logic                                          timer_evt_o;

  pattern_t                        patterns[$];
  cluster_periph_pkg::periph_rsp_t rsp_seen[$];
  cluster_periph_pkg::periph_rsp_t held_rsp;
  logic                            held;
  logic [31:0]                     lcg_state;
  logic [31:0]                     cur_test;
  logic                            load_ok;
  logic                            mon_on;
  logic                            watchdog_go;
  int                              error_count;
  int                              test_errors;
  int                              test_ops;
  int                              n_req;
  int                              n_rsp;
  int                              stall_count;

  // expected DUT outputs from the register rules
  logic                            exp_eoc;
  logic [7:0]                      exp_fetch;
  logic [31:0]                     exp_boot;
  logic                            exp_evt;
  logic                            evt_known;

  cluster_periph_top u_dut (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .req_valid_i    ( req_valid_i    ),
    .req_i          ( req_i          ),
    .req_ready_o    ( req_ready_o    ),
    .rsp_valid_o    ( rsp_valid_o    ),
    .rsp_o          ( rsp_o          ),
    .rsp_ready_i    ( rsp_ready_i    ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    ),
    .timer_evt_o    ( timer_evt_o    )
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #2 clk_i = ~clk_i;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic flag_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    $display("Error at %0d ns: test %0d %s is %h, expected %h", $time, cur_test, what, got, exp);
    error_count++;
    test_errors++;
  endtask

  task automatic load_patterns(output logic ok);
    int          fd;
    int          code;
    string       line;
    pattern_t    p;
    logic [31:0] a;
    logic [31:0] wd;
    logic [31:0] rd;
    logic [31:0] er;
    logic [31:0] tn;
    fd = $fopen("cluster_periph_patterns.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        // comment and blank lines fall through
        if (code > 2 && (line[0] == "R" || line[0] == "W" || line[0] == "E")) begin
          code = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %d", a, wd, rd, er, tn);
          if (code != 5) begin
            ok = 1'b0;
          end
          p.op    = line[0];
          p.addr  = a[11:0];
          p.wdata = wd;
          p.rdata = rd;
          p.err   = er[0];
          p.test  = tn;
          patterns.push_back(p);
        end
      end
      $fclose(fd);
      ok = ok && (patterns.size() > 0);
    end
  endtask

  // ************************************************************************
  // expected outputs and their checks
  // ************************************************************************

  // writes land on the acceptance edge
  task automatic update_model(input pattern_t p);
    if (p.op == "W" && p.addr[11:8] == 4'h0) begin
      case (p.addr[7:0])
        8'h00:   exp_eoc   = p.wdata[0];
        8'h04:   exp_fetch = p.wdata[7:0];
        8'h08:   exp_boot  = p.wdata;
        default: ;
      endcase
    end
    // event time unknown until the E step sees it
    if (p.op == "W" && p.addr == 12'h100 && p.wdata[0]) begin
      evt_known = 1'b0;
    end
    if (p.op == "W" && p.addr == 12'h10C && p.wdata[0]) begin
      exp_evt   = 1'b0;
      evt_known = 1'b1;
    end
  endtask

  task automatic check_outputs();
    if (eoc_o !== exp_eoc) begin
      flag_value("eoc_o", {31'd0, eoc_o}, {31'd0, exp_eoc});
    end
    if (fetch_enable_o !== exp_fetch) begin
      flag_value("fetch_enable_o", {24'd0, fetch_enable_o}, {24'd0, exp_fetch});
    end
    if (boot_addr_o !== exp_boot) begin
      flag_value("boot_addr_o", boot_addr_o, exp_boot);
    end
    if (evt_known && timer_evt_o !== exp_evt) begin
      flag_value("timer_evt_o", {31'd0, timer_evt_o}, {31'd0, exp_evt});
    end
  endtask

  // ************************************************************************
  // bus driver
  // ************************************************************************

  task automatic do_access(input pattern_t p);
    cluster_periph_pkg::periph_rsp_t got;
    logic                            accepted;
    @(negedge clk_i);
    req_i.we    = (p.op == "W");
    req_i.addr  = p.addr;
    req_i.wdata = p.wdata;
    req_valid_i = 1'b1;
    accepted    = 1'b0;
    while (!accepted) begin
      #1;
      accepted = req_ready_o;
      @(negedge clk_i);
    end
    req_valid_i = 1'b0;
    n_req++;
    update_model(p);
    while (rsp_seen.size() == 0) begin
      @(posedge clk_i);
    end
    got = rsp_seen.pop_front();
    if (got.rdata !== p.rdata) begin
      flag_value("read data", got.rdata, p.rdata);
    end
    if (got.err !== p.err) begin
      flag_value("error bit", {31'd0, got.err}, {31'd0, p.err});
    end
    @(negedge clk_i);
    check_outputs();
  endtask

  task automatic wait_event();
    int waited;
    waited = 0;
    while (timer_evt_o !== 1'b1 && waited < EVT_WAIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (timer_evt_o !== 1'b1) begin
      $display("test %0d: timer_evt_o did not rise within %0d cycles", cur_test, EVT_WAIT);
      error_count++;
      test_errors++;
    end else begin
      exp_evt   = 1'b1;
      evt_known = 1'b1;
    end
  endtask

  task automatic close_test();
    $display("test %0d done: %0d operations, %0d errors", cur_test, test_ops, test_errors);
    test_ops    = 0;
    test_errors = 0;
  endtask

  // ************************************************************************
  // response monitor with random back-pressure
  // ************************************************************************

  initial begin
    rsp_ready_i = 1'b1;
    held        = 1'b0;
    held_rsp    = '0;
    lcg_state   = 32'd91;
    forever begin
      @(negedge clk_i);
      if (mon_on) begin
        if (held && rsp_valid_o !== 1'b1) begin
          flag_value("stalled rsp_valid_o", {31'd0, rsp_valid_o}, 32'd1);
        end
        if (held && rsp_o !== held_rsp) begin
          flag_value("stalled rsp_o data", rsp_o.rdata, held_rsp.rdata);
        end
        lcg_state   = lcg_next(lcg_state);
        // about one cycle in four refuses the response
        rsp_ready_i = (lcg_state[17:16] != 2'b00);
        if (rsp_valid_o && rsp_ready_i) begin
          rsp_seen.push_back(rsp_o);
          n_rsp++;
        end
        held     = rsp_valid_o && !rsp_ready_i;
        held_rsp = rsp_o;
        if (held) begin
          stall_count++;
        end
        // with a response waiting, a new request only goes in as it transfers
        if (rsp_valid_o === 1'b1) begin
          #1;
          if (req_ready_o !== rsp_ready_i) begin
            flag_value("req_ready_o", {31'd0, req_ready_o}, {31'd0, rsp_ready_i});
          end
        end
      end
    end
  end

  initial begin
    wait (watchdog_go);
    repeat (patterns.size() * WDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired: the patterns did not complete in time");
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    mon_on      = 1'b0;
    watchdog_go = 1'b0;
    error_count = 0;
    test_errors = 0;
    test_ops    = 0;
    n_req       = 0;
    n_rsp       = 0;
    stall_count = 0;
    exp_eoc     = 1'b0;
    exp_fetch   = '0;
    exp_boot    = BOOT_RESET;
    exp_evt     = 1'b0;
    evt_known   = 1'b1;
    cur_test    = 32'd1;
    load_patterns(load_ok);
    if (!load_ok) begin
      $display("pattern file cluster_periph_patterns.txt is missing or malformed");
      error_count++;
    end else begin
      watchdog_go = 1'b1;
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;
      #1;
      if (rsp_valid_o !== 1'b0) begin
        flag_value("rsp_valid_o after reset", {31'd0, rsp_valid_o}, 32'd0);
      end
      if (req_ready_o !== 1'b1) begin
        flag_value("req_ready_o after reset", {31'd0, req_ready_o}, 32'd1);
      end
      check_outputs();
      mon_on = 1'b1;
      foreach (patterns[i]) begin
        if (patterns[i].test != cur_test) begin
          close_test();
          cur_test = patterns[i].test;
        end
        test_ops++;
        if (patterns[i].op == "E") begin
          wait_event();
        end else begin
          do_access(patterns[i]);
        end
      end
      // extra cycles catch a stray response
      repeat (5) @(negedge clk_i);
      if (n_rsp != n_req) begin
        $display("got %0d responses for %0d requests", n_rsp, n_req);
        error_count++;
        test_errors++;
      end
      if (stall_count == 0) begin
        $display("random back-pressure never stalled a response");
        error_count++;
        test_errors++;
      end
      close_test();
    end
    $display("summary: %0d patterns, %0d requests, %0d responses, %0d stalls, %0d errors",
             patterns.size(), n_req, n_rsp, stall_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
cluster_periph_pkg.sv
cluster_ctrl_unit.sv
cluster_timer.sv
periph_bus_mux.sv
cluster_periph_top.sv
tb_cluster_periph.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --top-module tb_cluster_periph -f build.f
out=$(./obj_dir/Vtb_cluster_periph)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
  exit 0
else
  exit 1
fi

//--- cluster_periph_patterns.txt
# op addr wdata exp_rdata exp_err test (hex fields, test number in decimal)
# op is R for read, W for write, E for wait on timer_evt_o
R 000 00000000 00000000 0 1
R 004 00000000 00000000 0 1
R 008 00000000 1c000000 0 1
R 100 00000000 00000000 0 1
R 10c 00000000 00000000 0 1
W 004 000000a5 00000000 0 2
R 004 00000000 000000a5 0 2
W 008 1c008080 00000000 0 2
R 008 00000000 1c008080 0 2
W 000 00000001 00000000 0 2
R 000 00000000 00000001 0 2
W 004 fffffff3 00000000 0 2
R 004 00000000 000000f3 0 2
W 108 00000014 00000000 0 3
W 104 00000000 00000000 0 3
W 100 00000001 00000000 0 3
E 000 00000000 00000000 0 3
R 10c 00000000 00000001 0 3
W 10c 00000001 00000000 0 3
R 10c 00000000 00000000 0 3
R 200 00000000 00000000 1 4
R 00c 00000000 00000000 1 4
W 2f0 12345678 00000000 1 4
R 110 00000000 00000000 1 4
R 108 00000000 00000014 0 5
R 008 00000000 1c008080 0 5
R 004 00000000 000000f3 0 5
R 000 00000000 00000001 0 5
